// File: Makefile
# Verilator build for the debug UART testbench

VERILATOR ?= verilator
TOP       ?= tb_dem_uart_ahb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

# The run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: common/dii_pkg.sv
// Debug interconnect types
`default_nettype none

package dii_pkg;

  // One flit of the debug interconnect
  // A packet is a run of flits that ends on the one with last set
  typedef struct packed {
    logic        valid;
    logic        last;
    logic [15:0] data;
  } dii_flit;

  // Type word in the third flit, after the destination and the source
  // It is a full flit wide so that it compares directly with flit data
  typedef enum logic [15:0] {
    // Payload flits carry one character each in the low byte
    PKT_CHAR = 16'h0001,
    // Payload bit 0 reports whether a host is attached
    PKT_CTRL = 16'h0002
  } dii_pkt_type_e;

endpackage : dii_pkg

`default_nettype wire

// File: common/uart_defs.svh
// UART build parameters
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// Width of the AHB address and data buses
`define UART_XLEN 32

// Entries in each character FIFO, kept a power of two
`define UART_FIFO_DEPTH 8

// Destination word placed in the first flit of every outgoing packet
`define UART_HOST_DEST 16'h0000

`endif

// File: common/uart_pkg.sv
// UART register and bus types
`default_nettype none

package uart_pkg;

  // Register offsets of the 16550 block, taken from word address bits 4 to 2
  typedef enum logic [2:0] {
    REG_RBR_THR = 3'd0,
    REG_IER     = 3'd1,
    REG_IIR_FCR = 3'd2,
    REG_LCR     = 3'd3,
    REG_MCR     = 3'd4,
    REG_LSR     = 3'd5,
    REG_MSR     = 3'd6,
    REG_SCR     = 3'd7
  } uart_reg_e;

  // Interrupt identification codes in the low nibble of IIR
  // Bit 0 set means that no interrupt is pending, as on a real 16550
  typedef enum logic [3:0] {
    IIR_NONE      = 4'b0001,
    IIR_THR_EMPTY = 4'b0010,
    IIR_RX_DATA   = 4'b0100
  } uart_iir_e;

  // Direction of a single register request
  typedef enum logic {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } uart_bus_op_e;

endpackage : uart_pkg

`default_nettype wire

// File: dem_uart/dem_uart_emul.sv
// Debug packet UART emulation
`default_nettype none
`include "uart_defs.svh"

module dem_uart_emul (
  input  wire                   clk,
  input  wire                   arst_n_i,
  input  wire [15:0]            id_i,
  input  wire dii_pkg::dii_flit debug_in_i,
  output logic                  debug_in_ready_o,
  output dii_pkg::dii_flit      debug_out_o,
  input  wire                   debug_out_ready_i,
  input  wire                   tx_valid_i,
  input  wire [7:0]             tx_char_i,
  output logic                  tx_ready_o,
  output logic                  rx_valid_o,
  output logic [7:0]            rx_char_o,
  input  wire                   rx_ready_i,
  output logic                  drop_o
);
  import dii_pkg::*;

  typedef enum logic [1:0] {SEND_DEST, SEND_SRC, SEND_TYPE, SEND_CHAR} send_state_e;
  typedef enum logic [1:0] {RECV_DEST, RECV_SRC, RECV_TYPE, RECV_PAYLOAD} recv_state_e;

  send_state_e   send_q;
  send_state_e   send_d;
  recv_state_e   recv_q;
  dii_pkt_type_e type_q;
  logic [7:0]    char_q;
  logic          attached_q;
  logic          out_valid;
  logic          out_fire;
  logic          in_fire;
  logic          is_char;

  // Send side

  // The character is taken along with the destination flit
  // Later flits then no longer depend on the transmit FIFO
  assign tx_ready_o = (send_q == SEND_DEST) && debug_out_ready_i;

  // A packet starts once a character waits, and then runs to its end
  assign out_valid = (send_q != SEND_DEST) || tx_valid_i;
  assign out_fire  = out_valid && debug_out_ready_i;

  always_comb begin
    debug_out_o       = '0;
    debug_out_o.valid = out_valid;
    send_d            = send_q;
    case (send_q)
      SEND_DEST: begin
        debug_out_o.data = `UART_HOST_DEST;
        if (out_fire) send_d = SEND_SRC;
      end
      SEND_SRC: begin
        debug_out_o.data = id_i;
        if (out_fire) send_d = SEND_TYPE;
      end
      SEND_TYPE: begin
        debug_out_o.data = PKT_CHAR;
        if (out_fire) send_d = SEND_CHAR;
      end
      default: begin
        debug_out_o.last = 1'b1;
        debug_out_o.data = {8'h00, char_q};
        if (out_fire) send_d = SEND_DEST;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      send_q <= SEND_DEST;
    end else begin
      send_q <= send_d;
    end
  end

  always_ff @(posedge clk) begin
    if (tx_valid_i && tx_ready_o) begin
      char_q <= tx_char_i;
    end
  end

  // Receive side

  // Character payload waits for room in the receive FIFO
  // Header flits and control payload are always taken
  assign is_char          = type_q == PKT_CHAR;
  assign debug_in_ready_o = (recv_q != RECV_PAYLOAD) || !is_char || rx_ready_i;
  assign in_fire          = debug_in_i.valid && debug_in_ready_o;

  assign rx_valid_o = (recv_q == RECV_PAYLOAD) && is_char && debug_in_i.valid;
  assign rx_char_o  = debug_in_i.data[7:0];

  // Characters are dropped until a host reports that it is attached
  assign drop_o = !attached_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      recv_q     <= RECV_DEST;
      attached_q <= 1'b0;
    end else if (in_fire) begin
      if ((recv_q == RECV_PAYLOAD) && (type_q == PKT_CTRL)) begin
        attached_q <= debug_in_i.data[0];
      end
      // A short packet still ends on its last flit
      if (debug_in_i.last) begin
        recv_q <= RECV_DEST;
      end else begin
        case (recv_q)
          RECV_DEST: recv_q <= RECV_SRC;
          RECV_SRC:  recv_q <= RECV_TYPE;
          default:   recv_q <= RECV_PAYLOAD;
        endcase
      end
    end
  end

  // The type word is only read in the payload state, after it is loaded
  always_ff @(posedge clk) begin
    if (in_fire && (recv_q == RECV_TYPE)) begin
      type_q <= dii_pkt_type_e'(debug_in_i.data);
    end
  end

  a_last_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
    debug_out_o.last |-> debug_out_o.valid)
    else $error("outgoing flit has last set without valid");

endmodule : dem_uart_emul

`default_nettype wire

// File: source/ahb_bus_adapter.sv
// AHB-lite slave adapter
`default_nettype none
`include "uart_defs.svh"

module ahb_bus_adapter (
  input  wire                    clk,
  input  wire                    arst_n_i,
  input  wire                    hsel_i,
  input  wire [`UART_XLEN-1:0]   haddr_i,
  input  wire [`UART_XLEN-1:0]   hwdata_i,
  input  wire                    hwrite_i,
  input  wire [1:0]              htrans_i,
  output logic [`UART_XLEN-1:0]  hrdata_o,
  output logic                   hready_o,
  output logic                   hresp_o,
  output logic                   bus_req_o,
  output uart_pkg::uart_bus_op_e bus_op_o,
  output uart_pkg::uart_reg_e    bus_addr_o,
  output logic [7:0]             bus_wdata_o,
  input  wire                    bus_ack_i,
  input  wire [7:0]              bus_rdata_i
);
  import uart_pkg::*;

  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  logic start;
  logic busy_q;

  // A transfer starts when its address phase is sampled
  // Only NONSEQ is taken since bursts are not supported
  assign start = hsel_i && (htrans_i == HTRANS_NONSEQ) && hready_o;

  // The data phase waits until the register stage acknowledges
  // This gives one wait state, because the ack trails the request by a cycle
  assign hready_o = !busy_q || bus_ack_i;

  // Every transfer completes with OKAY
  assign hresp_o = 1'b0;

  // Write data is only valid in the data phase, which is the request cycle
  assign bus_wdata_o = hwdata_i[7:0];

  // The read byte shows on every lane so any byte lane order works
  assign hrdata_o = {4{bus_rdata_i}};

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q    <= 1'b0;
      bus_req_o <= 1'b0;
    end else begin
      // The request is a single-cycle strobe in the data phase
      bus_req_o <= start;
      if (start) begin
        busy_q <= 1'b1;
      end else if (bus_ack_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Address phase controls are held for the data phase
  always_ff @(posedge clk) begin
    if (start) begin
      bus_op_o   <= hwrite_i ? BUS_WRITE : BUS_READ;
      bus_addr_o <= uart_reg_e'(haddr_i[4:2]);
    end
  end

  // A second request can only start after the ack of the first one
  a_req_single: assert property (@(posedge clk) disable iff (!arst_n_i)
    bus_req_o |=> !bus_req_o)
    else $error("bus request held for two cycles");

endmodule : ahb_bus_adapter

`default_nettype wire

// File: source/dem_uart_ahb_top.sv
// Debug UART with AHB port
`default_nettype none
`include "uart_defs.svh"

module dem_uart_ahb_top (
  input  wire                   clk,
  input  wire                   arst_n_i,
  input  wire                   hsel_i,
  input  wire [`UART_XLEN-1:0]  haddr_i,
  input  wire [`UART_XLEN-1:0]  hwdata_i,
  input  wire                   hwrite_i,
  input  wire [1:0]             htrans_i,
  output logic [`UART_XLEN-1:0] hrdata_o,
  output logic                  hready_o,
  output logic                  hresp_o,
  input  wire dii_pkg::dii_flit debug_in_i,
  output logic                  debug_in_ready_o,
  output dii_pkg::dii_flit      debug_out_o,
  input  wire                   debug_out_ready_i,
  input  wire [15:0]            id_i,
  output logic                  irq_o
);
  import uart_pkg::*;

  // Register requests from the bus adapter
  logic         bus_req;
  uart_bus_op_e bus_op;
  uart_reg_e    bus_addr;
  logic [7:0]   bus_wdata;
  logic [7:0]   bus_rdata;
  logic         bus_ack;

  // Character streams between the registers and the packet stage
  logic         tx_valid;
  logic [7:0]   tx_char;
  logic         tx_ready;
  logic         rx_valid;
  logic [7:0]   rx_char;
  logic         rx_ready;
  logic         drop;

  ahb_bus_adapter u_bus (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .hsel_i      (hsel_i),
    .haddr_i     (haddr_i),
    .hwdata_i    (hwdata_i),
    .hwrite_i    (hwrite_i),
    .htrans_i    (htrans_i),
    .hrdata_o    (hrdata_o),
    .hready_o    (hready_o),
    .hresp_o     (hresp_o),
    .bus_req_o   (bus_req),
    .bus_op_o    (bus_op),
    .bus_addr_o  (bus_addr),
    .bus_wdata_o (bus_wdata),
    .bus_ack_i   (bus_ack),
    .bus_rdata_i (bus_rdata)
  );

  uart_16550_regs u_regs (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .bus_req_i   (bus_req),
    .bus_op_i    (bus_op),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .bus_ack_o   (bus_ack),
    .bus_rdata_o (bus_rdata),
    .tx_valid_o  (tx_valid),
    .tx_char_o   (tx_char),
    .tx_ready_i  (tx_ready),
    .rx_valid_i  (rx_valid),
    .rx_char_i   (rx_char),
    .rx_ready_o  (rx_ready),
    .drop_i      (drop),
    .irq_o       (irq_o)
  );

  dem_uart_emul u_emul (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .id_i              (id_i),
    .debug_in_i        (debug_in_i),
    .debug_in_ready_o  (debug_in_ready_o),
    .debug_out_o       (debug_out_o),
    .debug_out_ready_i (debug_out_ready_i),
    .tx_valid_i        (tx_valid),
    .tx_char_i         (tx_char),
    .tx_ready_o        (tx_ready),
    .rx_valid_o        (rx_valid),
    .rx_char_o         (rx_char),
    .rx_ready_i        (rx_ready),
    .drop_o            (drop)
  );

endmodule : dem_uart_ahb_top

`default_nettype wire

// File: test/tb_dem_uart_ahb.sv
// Debug UART testbench
`default_nettype none
`include "uart_defs.svh"

module tb_dem_uart_ahb;
  timeunit 1ns;
  timeprecision 100ps;

  import uart_pkg::*;
  import dii_pkg::*;

  // Source word that the DUT puts in the second flit of its packets
  localparam logic [15:0] MODULE_ID     = 16'h0c5a;
  localparam logic [1:0]  HTRANS_IDLE   = 2'b00;
  localparam logic [1:0]  HTRANS_NONSEQ = 2'b10;

  typedef enum {K_WRITE, K_READ, K_INJECT, K_EXPECT, K_IRQ} kind_e;

  logic                  clk;
  logic                  arst_n_i;
  logic                  hsel_i;
  logic [`UART_XLEN-1:0] haddr_i;
  logic [`UART_XLEN-1:0] hwdata_i;
  logic                  hwrite_i;
  logic [1:0]            htrans_i;
  logic [`UART_XLEN-1:0] hrdata_o;
  logic                  hready_o;
  logic                  hresp_o;
  dii_flit               debug_in_i;
  logic                  debug_in_ready_o;
  dii_flit               debug_out_o;
  logic                  debug_out_ready_i;
  logic [15:0]           id_i;
  logic                  irq_o;

  // Stimulus table, one slot per field
  // The select field holds a register offset or a packet type
  string       t_name [$];
  kind_e       t_kind [$];
  logic [15:0] t_sel  [$];
  logic [7:0]  t_data [$];
  logic [7:0]  t_exp  [$];

  int                    seed = 32'hb2b0e413;
  int                    errors;
  int                    checks;
  int                    cycles;
  int                    limit;
  logic [7:0]            scratch;
  logic [`UART_XLEN-1:0] rdata;

  dem_uart_ahb_top u_dut (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .hsel_i            (hsel_i),
    .haddr_i           (haddr_i),
    .hwdata_i          (hwdata_i),
    .hwrite_i          (hwrite_i),
    .htrans_i          (htrans_i),
    .hrdata_o          (hrdata_o),
    .hready_o          (hready_o),
    .hresp_o           (hresp_o),
    .debug_in_i        (debug_in_i),
    .debug_in_ready_o  (debug_in_ready_o),
    .debug_out_o       (debug_out_o),
    .debug_out_ready_i (debug_out_ready_i),
    .id_i              (id_i),
    .irq_o             (irq_o)
  );

  always #50 clk = ~clk;

  // Run limit, set once the table length is known
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected 8'h%h, actual 8'h%h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_flit(input string name, input dii_flit exp, input dii_flit act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected valid=%b last=%b data=%h, actual valid=%b last=%b data=%h",
               name, exp.valid, exp.last, exp.data, act.valid, act.last, act.data);
    end
  endtask

  task automatic check_iir(input string name, input uart_iir_e exp, input uart_iir_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %s (%h), actual %s (%h)",
               name, exp.name(), exp, act.name(), act);
    end
  endtask

  task automatic add_entry(input string name, input kind_e kind, input logic [15:0] sel,
                           input logic [7:0] data, input logic [7:0] exp);
    t_name.push_back(name);
    t_kind.push_back(kind);
    t_sel.push_back(sel);
    t_data.push_back(data);
    t_exp.push_back(exp);
  endtask

  task automatic add_bus(input string name, input kind_e kind, input uart_reg_e offset,
                         input logic [7:0] data, input logic [7:0] exp);
    add_entry(name, kind, {13'd0, offset}, data, exp);
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    rnd = $random(seed);
    scratch = rnd[7:0];
    // Register access, LSR idles at THRE and TEMT with no data ready
    add_bus("scr_write", K_WRITE, REG_SCR, scratch, 8'h00);
    add_bus("scr_read", K_READ, REG_SCR, 8'h00, scratch);
    add_bus("lsr_reset", K_READ, REG_LSR, 8'h00, 8'h60);
    // No host yet, so the character must vanish
    add_bus("thr_detached", K_WRITE, REG_RBR_THR, 8'h41, 8'h00);
    add_entry("no_flit_detached", K_EXPECT, 16'h0000, 8'd4, 8'h00);
    add_bus("lsr_after_drop", K_READ, REG_LSR, 8'h00, 8'h60);
    // Attach and send, once freely and once under back-pressure
    add_entry("attach", K_INJECT, PKT_CTRL, 8'h01, 8'h00);
    add_bus("thr_char", K_WRITE, REG_RBR_THR, 8'h5a, 8'h00);
    add_entry("tx_packet", K_EXPECT, PKT_CHAR, 8'd0, 8'h5a);
    add_bus("thr_char_stall", K_WRITE, REG_RBR_THR, 8'hc3, 8'h00);
    add_entry("tx_packet_stall", K_EXPECT, PKT_CHAR, 8'd3, 8'hc3);
    // Receive one character through RBR
    add_entry("rx_inject", K_INJECT, PKT_CHAR, 8'h72, 8'h00);
    add_bus("lsr_rx_ready", K_READ, REG_LSR, 8'h00, 8'h61);
    add_bus("rbr_read", K_READ, REG_RBR_THR, 8'h00, 8'h72);
    add_bus("lsr_rx_empty", K_READ, REG_LSR, 8'h00, 8'h60);
    // Interrupt sources in priority order
    add_bus("ier_rx", K_WRITE, REG_IER, 8'h01, 8'h00);
    add_entry("irq_idle", K_IRQ, 16'h0000, 8'h00, 8'h00);
    add_entry("rx_inject_irq", K_INJECT, PKT_CHAR, 8'h33, 8'h00);
    add_bus("iir_rx", K_READ, REG_IIR_FCR, 8'h00, {4'h0, IIR_RX_DATA});
    add_entry("irq_rx", K_IRQ, 16'h0000, 8'h00, 8'h01);
    add_bus("rbr_irq", K_READ, REG_RBR_THR, 8'h00, 8'h33);
    add_bus("ier_thr", K_WRITE, REG_IER, 8'h02, 8'h00);
    add_bus("iir_thr", K_READ, REG_IIR_FCR, 8'h00, {4'h0, IIR_THR_EMPTY});
    add_entry("irq_thr", K_IRQ, 16'h0000, 8'h00, 8'h01);
    add_bus("ier_off", K_WRITE, REG_IER, 8'h00, 8'h00);
    add_bus("iir_none", K_READ, REG_IIR_FCR, 8'h00, {4'h0, IIR_NONE});
    add_entry("irq_none", K_IRQ, 16'h0000, 8'h00, 8'h00);
    // Fill the receive FIFO, then clear it through FCR
    add_entry("rx_fill_0", K_INJECT, PKT_CHAR, 8'h10, 8'h00);
    add_entry("rx_fill_1", K_INJECT, PKT_CHAR, 8'h11, 8'h00);
    add_entry("rx_fill_2", K_INJECT, PKT_CHAR, 8'h12, 8'h00);
    add_bus("lsr_filled", K_READ, REG_LSR, 8'h00, 8'h61);
    add_bus("fcr_clear", K_WRITE, REG_IIR_FCR, 8'h02, 8'h00);
    add_bus("lsr_cleared", K_READ, REG_LSR, 8'h00, 8'h60);
  endtask

  // One AHB transfer, started 5 ns after an edge and left at the same point
  task automatic bus_transfer(input string name, input uart_bus_op_e op,
                              input uart_reg_e offset, input logic [7:0] wdata,
                              output logic [`UART_XLEN-1:0] rd);
    logic [7:0] waits;
    hsel_i   = 1'b1;
    htrans_i = HTRANS_NONSEQ;
    hwrite_i = (op == BUS_WRITE);
    haddr_i  = {{(`UART_XLEN - 5){1'b0}}, offset, 2'b00};
    @(posedge clk);
    #5;
    // Data phase, the upper lanes carry junk that must be ignored
    hsel_i   = 1'b0;
    htrans_i = HTRANS_IDLE;
    hwrite_i = 1'b0;
    haddr_i  = '0;
    hwdata_i = {8'hde, 8'had, ~wdata, wdata};
    waits    = 8'd0;
    @(negedge clk);
    while (!hready_o) begin
      waits = waits + 8'd1;
      @(negedge clk);
    end
    rd = hrdata_o;
    check_byte({name, "_wait_states"}, 8'd1, waits);
    // Every transfer ends with an OKAY response
    check_bit({name, "_hresp"}, 1'b0, hresp_o);
    @(posedge clk);
    #5;
  endtask

  // Sends a four-flit packet from the host, waiting out refusals
  task automatic inject_packet(input logic [15:0] ptype, input logic [7:0] payload);
    logic [15:0] words [4];
    words[0] = MODULE_ID;
    words[1] = `UART_HOST_DEST;
    words[2] = ptype;
    words[3] = {8'h00, payload};
    for (int k = 0; k < 4; k++) begin
      debug_in_i.valid = 1'b1;
      debug_in_i.last  = (k == 3);
      debug_in_i.data  = words[k];
      @(negedge clk);
      while (!debug_in_ready_o) begin
        @(posedge clk);
        @(negedge clk);
      end
      @(posedge clk);
      #5;
    end
    debug_in_i = '0;
  endtask

  // Takes one outgoing packet, holding ready low for a while before each flit
  task automatic expect_packet(input string name, input logic [7:0] ch,
                               input logic [7:0] stall);
    dii_flit     exp_flit;
    logic [15:0] words [4];
    words[0] = `UART_HOST_DEST;
    words[1] = MODULE_ID;
    words[2] = PKT_CHAR;
    words[3] = {8'h00, ch};
    for (int k = 0; k < 4; k++) begin
      exp_flit.valid = 1'b1;
      exp_flit.last  = (k == 3);
      exp_flit.data  = words[k];
      debug_out_ready_i = 1'b0;
      // A stalled flit must hold its contents
      repeat (stall) begin
        @(negedge clk);
        check_flit({name, "_held"}, exp_flit, debug_out_o);
        @(posedge clk);
        #5;
      end
      debug_out_ready_i = 1'b1;
      @(negedge clk);
      while (!debug_out_o.valid) begin
        @(posedge clk);
        @(negedge clk);
      end
      check_flit(name, exp_flit, debug_out_o);
      @(posedge clk);
      #5;
    end
    debug_out_ready_i = 1'b0;
  endtask

  // Opens the port and watches that nothing comes out
  task automatic expect_idle(input string name, input logic [7:0] span);
    debug_out_ready_i = 1'b1;
    repeat (span) begin
      @(negedge clk);
      checks++;
      if (debug_out_o.valid) begin
        errors++;
        $display("%s: a flit appeared on debug_out_o although no host is attached", name);
      end
      @(posedge clk);
      #5;
    end
    debug_out_ready_i = 1'b0;
  endtask

  task automatic run_entry(input int i);
    uart_reg_e  offset;
    logic [7:0] lane;
    string      lane_name;
    offset = uart_reg_e'(t_sel[i][2:0]);
    case (t_kind[i])
      K_WRITE: bus_transfer(t_name[i], BUS_WRITE, offset, t_data[i], rdata);
      K_READ: begin
        bus_transfer(t_name[i], BUS_READ, offset, t_data[i], rdata);
        // The read byte is expected on each of the four byte lanes
        for (int b = 0; b < 4; b++) begin
          lane      = rdata[8*b +: 8];
          lane_name = $sformatf("%s_lane%0d", t_name[i], b);
          // Only the low nibble of IIR is the interrupt code
          if (offset == REG_IIR_FCR) begin
            check_iir(lane_name, uart_iir_e'(t_exp[i][3:0]), uart_iir_e'(lane[3:0]));
          end else begin
            check_byte(lane_name, t_exp[i], lane);
          end
        end
      end
      K_INJECT: inject_packet(t_sel[i], t_data[i]);
      K_EXPECT: begin
        if (t_sel[i] == PKT_CHAR) begin
          expect_packet(t_name[i], t_exp[i], t_data[i]);
        end else begin
          expect_idle(t_name[i], t_data[i]);
        end
      end
      default: check_bit(t_name[i], t_exp[i][0], irq_o);
    endcase
  endtask

  initial begin
    clk               = 1'b0;
    arst_n_i          = 1'b0;
    hsel_i            = 1'b0;
    haddr_i           = '0;
    hwdata_i          = '0;
    hwrite_i          = 1'b0;
    htrans_i          = HTRANS_IDLE;
    debug_in_i        = '0;
    debug_out_ready_i = 1'b0;
    id_i              = MODULE_ID;
    build_table();
    limit = t_name.size() * 20 + 10;
    repeat (4) @(posedge clk);
    #5;
    arst_n_i = 1'b1;
    // Idle state right after reset
    check_bit("reset_hready", 1'b1, hready_o);
    check_bit("reset_irq", 1'b0, irq_o);
    check_bit("reset_out_valid", 1'b0, debug_out_o.valid);
    check_bit("reset_in_ready", 1'b1, debug_in_ready_o);
    for (int i = 0; i < t_name.size(); i++) begin
      run_entry(i);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : tb_dem_uart_ahb

`default_nettype wire

// File: uart_16550/uart_16550_regs.sv
// 16550 register stage
`default_nettype none
`include "uart_defs.svh"

module uart_16550_regs (
  input  wire                    clk,
  input  wire                    arst_n_i,
  input  wire                    bus_req_i,
  input  uart_pkg::uart_bus_op_e bus_op_i,
  input  uart_pkg::uart_reg_e    bus_addr_i,
  input  wire [7:0]              bus_wdata_i,
  output logic                   bus_ack_o,
  output logic [7:0]             bus_rdata_o,
  output logic                   tx_valid_o,
  output logic [7:0]             tx_char_o,
  input  wire                    tx_ready_i,
  input  wire                    rx_valid_i,
  input  wire [7:0]              rx_char_i,
  output logic                   rx_ready_o,
  input  wire                    drop_i,
  output logic                   irq_o
);
  import uart_pkg::*;

  logic [7:0] ier_q;
  logic [7:0] lcr_q;
  logic [7:0] mcr_q;
  logic [7:0] scr_q;
  logic [7:0] dll_q;
  logic [7:0] dlm_q;
  logic       dlab;
  logic       wr_en;
  logic       rd_en;
  logic       fcr_wr;
  logic       tx_push;
  logic       tx_pop;
  logic       tx_empty;
  logic       rx_push;
  logic       rx_pop;
  logic       rx_full;
  logic       rx_empty;
  logic [7:0] rx_data;
  logic [7:0] lsr;
  logic [7:0] rdata_d;
  uart_iir_e  iir;

  // LCR bit 7 maps offsets 0 and 1 onto the divisor latch
  assign dlab  = lcr_q[7];
  assign wr_en = bus_req_i && (bus_op_i == BUS_WRITE);
  assign rd_en = bus_req_i && (bus_op_i == BUS_READ);

  assign tx_push = wr_en && (bus_addr_i == REG_RBR_THR) && !dlab;
  assign rx_pop  = rd_en && (bus_addr_i == REG_RBR_THR) && !dlab;
  assign fcr_wr  = wr_en && (bus_addr_i == REG_IIR_FCR);

  // Without a host the head character is thrown away at once
  assign tx_valid_o = !tx_empty && !drop_i;
  assign tx_pop     = !tx_empty && (drop_i || tx_ready_i);

  // The receive side takes characters while there is room
  assign rx_ready_o = !rx_full;
  assign rx_push    = rx_valid_i && rx_ready_o;

  // Write pushes that find the FIFO full are lost
  uart_char_fifo #(
    .DEPTH (`UART_FIFO_DEPTH)
  ) u_tx_fifo (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .push_i      (tx_push),
    .push_data_i (bus_wdata_i),
    .pop_i       (tx_pop),
    .clear_i     (fcr_wr && bus_wdata_i[2]),
    .pop_data_o  (tx_char_o),
    .full_o      (),
    .empty_o     (tx_empty),
    .level_o     ()
  );

  uart_char_fifo #(
    .DEPTH (`UART_FIFO_DEPTH)
  ) u_rx_fifo (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .push_i      (rx_push),
    .push_data_i (rx_char_i),
    .pop_i       (rx_pop),
    .clear_i     (fcr_wr && bus_wdata_i[1]),
    .pop_data_o  (rx_data),
    .full_o      (rx_full),
    .empty_o     (rx_empty),
    .level_o     ()
  );

  // No shift register exists, so TEMT follows THRE
  // A full transmit FIFO only shows by its lost writes
  assign lsr = {1'b0, tx_empty, tx_empty, 4'b0000, !rx_empty};

  // Received data outranks an empty transmitter
  always_comb begin
    if (ier_q[0] && !rx_empty) begin
      iir = IIR_RX_DATA;
    end else if (ier_q[1] && tx_empty) begin
      iir = IIR_THR_EMPTY;
    end else begin
      iir = IIR_NONE;
    end
  end

  assign irq_o = iir != IIR_NONE;

  always_comb begin
    case (bus_addr_i)
      REG_RBR_THR: rdata_d = dlab ? dll_q : rx_data;
      REG_IER:     rdata_d = dlab ? dlm_q : ier_q;
      // Bits 7 and 6 report the FIFOs as enabled
      REG_IIR_FCR: rdata_d = {4'b1100, iir};
      REG_LCR:     rdata_d = lcr_q;
      REG_MCR:     rdata_d = mcr_q;
      REG_LSR:     rdata_d = lsr;
      // There are no modem lines to report
      REG_MSR:     rdata_d = 8'h00;
      REG_SCR:     rdata_d = scr_q;
      default:     rdata_d = 8'h00;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ier_q     <= '0;
      lcr_q     <= '0;
      mcr_q     <= '0;
      scr_q     <= '0;
      dll_q     <= '0;
      dlm_q     <= '0;
      bus_ack_o <= 1'b0;
    end else begin
      // Every request is answered exactly one cycle later
      bus_ack_o <= bus_req_i;
      if (wr_en) begin
        case (bus_addr_i)
          REG_RBR_THR: begin
            if (dlab) begin
              dll_q <= bus_wdata_i;
            end
          end
          REG_IER: begin
            if (dlab) begin
              dlm_q <= bus_wdata_i;
            end else begin
              ier_q <= bus_wdata_i;
            end
          end
          REG_LCR: lcr_q <= bus_wdata_i;
          REG_MCR: mcr_q <= bus_wdata_i;
          REG_SCR: scr_q <= bus_wdata_i;
          default: ;
        endcase
      end
    end
  end

  // Read data is taken before an RBR pop moves the head
  always_ff @(posedge clk) begin
    if (bus_req_i) begin
      bus_rdata_o <= rdata_d;
    end
  end

endmodule : uart_16550_regs

`default_nettype wire

// File: uart_16550/uart_char_fifo.sv
// Character FIFO
`default_nettype none

module uart_char_fifo #(
  parameter int DEPTH = 8
) (
  input  wire                    clk,
  input  wire                    arst_n_i,
  input  wire                    push_i,
  input  wire [7:0]              push_data_i,
  input  wire                    pop_i,
  input  wire                    clear_i,
  output logic [7:0]             pop_data_o,
  output logic                   full_o,
  output logic                   empty_o,
  output logic [$clog2(DEPTH):0] level_o
);

  localparam int AW = $clog2(DEPTH);

  logic [7:0]  mem [DEPTH];
  logic [AW:0] wr_ptr_q;
  logic [AW:0] rd_ptr_q;
  logic        push_ok;
  logic        pop_ok;

  // The pointers carry one wrap bit, which tells full from empty
  assign empty_o = wr_ptr_q == rd_ptr_q;
  assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                   (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
  assign level_o = wr_ptr_q - rd_ptr_q;

  // Pushes to a full buffer and pops from an empty one are dropped
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  // The head entry is always visible on the output
  assign pop_data_o = mem[rd_ptr_q[AW-1:0]];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr_q[AW-1:0]] <= push_data_i;
    end
  end

  // A full buffer keeps its write pointer until something is popped or cleared
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n_i)
    full_o && !clear_i |=> wr_ptr_q == $past(wr_ptr_q))
    else $error("character FIFO accepted a push while full");

endmodule : uart_char_fifo

`default_nettype wire

// File: verilog.f
+incdir+common
common/dii_pkg.sv
common/uart_pkg.sv
source/ahb_bus_adapter.sv
uart_16550/uart_char_fifo.sv
uart_16550/uart_16550_regs.sv
dem_uart/dem_uart_emul.sv
source/dem_uart_ahb_top.sv
test/tb_dem_uart_ahb.sv
